// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mci_top_tb
RTL_TOP   := mci_top
FILELIST  := mci_top.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mci_top.f ====
+incdir+rtl
rtl/mci_pkg.sv
rtl/mci_wdt.sv
rtl/mci_error_sticky.sv
rtl/mci_error_agg.sv
rtl/mci_top.sv
test/mci_top_tb.sv

// ==== rtl/mci_config.svh ====
// Build-time sizes for the management block, included by the RTL and the testbench
`ifndef MCI_CONFIG_SVH
`define MCI_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Watchdog
//////////////////////////////////////////////////////////////////////

// Width of both watchdog counters and of the period inputs
`define MCI_WDT_CNT_W 16

//////////////////////////////////////////////////////////////////////
// Error aggregation
//////////////////////////////////////////////////////////////////////

// Number of aggregated error sources per severity
`define MCI_AGG_ERR_W 8

// Flop depth of the synchronizer in front of the aggregated sources
`define MCI_SYNC_STAGES 2

`endif

// ==== rtl/mci_error_agg.sv ====
// Synchronizes and masks the aggregated error sources and forms the two summary outputs
`timescale 1ns/1ns
`include "mci_config.svh"

module mci_error_agg (
  input  logic              core_clk_i,
  input  logic              rst_n_i,
  input  mci_pkg::agg_err_t agg_fatal_i,
  input  mci_pkg::agg_err_t agg_fatal_mask_i,
  input  mci_pkg::agg_err_t agg_non_fatal_i,
  input  mci_pkg::agg_err_t agg_non_fatal_mask_i,
  input  logic              hw_fatal_any_i,
  input  logic              hw_non_fatal_any_i,
  output logic              all_error_fatal_o,
  output logic              all_error_non_fatal_o
);

  import mci_pkg::*;

  // Index 0 is the fatal path and index 1 the non-fatal path
  localparam int NUM_SEV = 2;
  localparam int LAST    = `MCI_SYNC_STAGES - 1;

  agg_err_t             src    [NUM_SEV];
  agg_err_t             mask   [NUM_SEV];
  agg_err_t             sync_q [NUM_SEV][`MCI_SYNC_STAGES];
  logic [NUM_SEV-1:0]   hw_any;
  logic [NUM_SEV-1:0]   all_err_q;

  assign src[0]  = agg_fatal_i;
  assign src[1]  = agg_non_fatal_i;
  assign mask[0] = agg_fatal_mask_i;
  assign mask[1] = agg_non_fatal_mask_i;
  assign hw_any  = {hw_non_fatal_any_i, hw_fatal_any_i};

  //////////////////////////////////////////////////////////////////////
  // Synchronizer and summary register
  //////////////////////////////////////////////////////////////////////

  // Sources come from other blocks, so they pass the synchronizer before masking.
  // The mask is local and is applied at the output register
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      all_err_q <= '0;
      for (int s = 0; s < NUM_SEV; s++) begin
        for (int k = 0; k < `MCI_SYNC_STAGES; k++) begin
          sync_q[s][k] <= '0;
        end
      end
    end else begin
      for (int s = 0; s < NUM_SEV; s++) begin
        sync_q[s][0] <= src[s];
        for (int k = 1; k < `MCI_SYNC_STAGES; k++) begin
          sync_q[s][k] <= sync_q[s][k-1];
        end
        all_err_q[s] <= (|(sync_q[s][LAST] & ~mask[s])) | hw_any[s];
      end
    end
  end

  assign all_error_fatal_o     = all_err_q[0];
  assign all_error_non_fatal_o = all_err_q[1];

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_SEV; g++) begin : g_agg_chk
    // A synchronized source that is not masked sets the summary on the next edge
    agg_unmasked_sets_a: assert property (
      @(posedge core_clk_i) disable iff (!rst_n_i)
      (|(sync_q[g][LAST] & ~mask[g])) |=> all_err_q[g]
    ) else $error("Summary output %0d missed an unmasked aggregated source", g);
  end

endmodule

// ==== rtl/mci_error_sticky.sv ====
// Sticky error status register with write-one-to-clear and mask, one instance per payload type
`timescale 1ns/1ns

module mci_error_sticky #(
  parameter type err_t = logic
) (
  input  logic core_clk_i,
  input  logic rst_n_i,
  input  err_t event_i,
  input  err_t clear_i,
  input  err_t mask_i,
  output err_t status_o,
  output logic any_o
);

  localparam int ERR_W = $bits(err_t);

  logic [ERR_W-1:0] event_vec;
  logic [ERR_W-1:0] clear_vec;
  logic [ERR_W-1:0] mask_vec;
  logic [ERR_W-1:0] status_q;

  // Work on flat vectors so the same code fits any packed payload
  assign event_vec = event_i;
  assign clear_vec = clear_i;
  assign mask_vec  = mask_i;

  //////////////////////////////////////////////////////////////////////
  // Status register
  //////////////////////////////////////////////////////////////////////

  // A new event wins over a clear of the same bit on the same edge
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~clear_vec) | event_vec;
    end
  end

  assign status_o = err_t'(status_q);

  // Only unmasked bits reach the summary
  assign any_o = |(status_q & ~mask_vec);

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Every event bit shows up in the status one cycle after it is sampled
  event_sticks_a: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    (|event_vec) |=> ((status_q & $past(event_vec)) == $past(event_vec))
  ) else $error("Sticky status missing an event bit");

endmodule

// ==== rtl/mci_pkg.sv ====
// Error payload and counter types shared by the management block RTL and its testbench
`include "mci_config.svh"

package mci_pkg;

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  typedef logic [`MCI_WDT_CNT_W-1:0] wdt_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////////////////////////

  // One bit per aggregated source, bit 0 is source 0
  typedef logic [`MCI_AGG_ERR_W-1:0] agg_err_t;

  // Hardware fatal events, nmi_pin comes from the timer2 expiry
  typedef struct packed {
    logic nmi_pin;
    logic sram_ecc_unc;
    logic dmi_axi_collision;
  } hw_fatal_t;

  // Hardware non-fatal events from the two mailbox SRAMs
  typedef struct packed {
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } hw_non_fatal_t;

endpackage

// ==== rtl/mci_top.sv ====
// Management block top level joining the watchdog, the sticky error registers and the aggregator
`timescale 1ns/1ns

module mci_top (
  input  logic                  core_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wdt_t1_en_i,
  input  logic                  wdt_t2_en_i,
  input  logic                  wdt_t1_restart_i,
  input  logic                  wdt_t2_restart_i,
  input  logic                  wdt_t1_service_i,
  input  logic                  wdt_t2_service_i,
  input  mci_pkg::wdt_cnt_t     wdt_t1_period_i,
  input  mci_pkg::wdt_cnt_t     wdt_t2_period_i,
  output logic                  wdt_t1_timeout_o,
  output logic                  wdt_t2_timeout_o,
  input  logic                  sram_ecc_unc_i,
  input  logic                  dmi_axi_collision_i,
  input  logic                  mbox0_ecc_unc_i,
  input  logic                  mbox1_ecc_unc_i,
  input  mci_pkg::hw_fatal_t     hw_fatal_clear_i,
  input  mci_pkg::hw_fatal_t     hw_fatal_mask_i,
  input  mci_pkg::hw_non_fatal_t hw_non_fatal_clear_i,
  input  mci_pkg::hw_non_fatal_t hw_non_fatal_mask_i,
  output mci_pkg::hw_fatal_t     hw_fatal_status_o,
  output mci_pkg::hw_non_fatal_t hw_non_fatal_status_o,
  input  mci_pkg::agg_err_t     agg_fatal_i,
  input  mci_pkg::agg_err_t     agg_fatal_mask_i,
  input  mci_pkg::agg_err_t     agg_non_fatal_i,
  input  mci_pkg::agg_err_t     agg_non_fatal_mask_i,
  output logic                  all_error_fatal_o,
  output logic                  all_error_non_fatal_o
);

  import mci_pkg::*;

  logic          t2_timeout_d_q;
  logic          nmi_rise;
  hw_fatal_t     fatal_event;
  hw_non_fatal_t non_fatal_event;
  logic          hw_fatal_any;
  logic          hw_non_fatal_any;

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  mci_wdt mci_wdt_i (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .t1_en_i      (wdt_t1_en_i),
    .t2_en_i      (wdt_t2_en_i),
    .t1_restart_i (wdt_t1_restart_i),
    .t2_restart_i (wdt_t2_restart_i),
    .t1_service_i (wdt_t1_service_i),
    .t2_service_i (wdt_t2_service_i),
    .t1_period_i  (wdt_t1_period_i),
    .t2_period_i  (wdt_t2_period_i),
    .t1_timeout_o (wdt_t1_timeout_o),
    .t2_timeout_o (wdt_t2_timeout_o)
  );

  // The NMI event is a single pulse on the rising edge of the timer2 timeout
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      t2_timeout_d_q <= 1'b0;
    end else begin
      t2_timeout_d_q <= wdt_t2_timeout_o;
    end
  end

  assign nmi_rise = wdt_t2_timeout_o & ~t2_timeout_d_q;

  //////////////////////////////////////////////////////////////////////
  // Hardware error status
  //////////////////////////////////////////////////////////////////////

  assign fatal_event.nmi_pin               = nmi_rise;
  assign fatal_event.sram_ecc_unc          = sram_ecc_unc_i;
  assign fatal_event.dmi_axi_collision     = dmi_axi_collision_i;
  assign non_fatal_event.mbox0_ecc_unc     = mbox0_ecc_unc_i;
  assign non_fatal_event.mbox1_ecc_unc     = mbox1_ecc_unc_i;

  mci_error_sticky #(.err_t(hw_fatal_t)) hw_fatal_i (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .event_i    (fatal_event),
    .clear_i    (hw_fatal_clear_i),
    .mask_i     (hw_fatal_mask_i),
    .status_o   (hw_fatal_status_o),
    .any_o      (hw_fatal_any)
  );

  mci_error_sticky #(.err_t(hw_non_fatal_t)) hw_non_fatal_i (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .event_i    (non_fatal_event),
    .clear_i    (hw_non_fatal_clear_i),
    .mask_i     (hw_non_fatal_mask_i),
    .status_o   (hw_non_fatal_status_o),
    .any_o      (hw_non_fatal_any)
  );

  //////////////////////////////////////////////////////////////////////
  // Summary outputs
  //////////////////////////////////////////////////////////////////////

  mci_error_agg mci_error_agg_i (
    .core_clk_i            (core_clk_i),
    .rst_n_i               (rst_n_i),
    .agg_fatal_i           (agg_fatal_i),
    .agg_fatal_mask_i      (agg_fatal_mask_i),
    .agg_non_fatal_i       (agg_non_fatal_i),
    .agg_non_fatal_mask_i  (agg_non_fatal_mask_i),
    .hw_fatal_any_i        (hw_fatal_any),
    .hw_non_fatal_any_i    (hw_non_fatal_any),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

  // Timer2 expiry lands in the fatal status one cycle after the timeout rises
  wdt_nmi_status_a: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    $rose(wdt_t2_timeout_o) |=> hw_fatal_status_o.nmi_pin
  ) else $error("nmi_pin not set after timer2 expiry");

  // An unmasked NMI status drives the fatal summary on the next edge
  nmi_summary_a: assert property (
    @(posedge core_clk_i) disable iff (!rst_n_i)
    (hw_fatal_status_o.nmi_pin && !hw_fatal_mask_i.nmi_pin) |=> all_error_fatal_o
  ) else $error("all_error_fatal_o not set for unmasked nmi_pin");

endmodule

// ==== rtl/mci_wdt.sv ====
// Two-timer watchdog, independent when t2_en_i is high and cascaded behind timer1 otherwise
`timescale 1ns/1ns

module mci_wdt (
  input  logic              core_clk_i,
  input  logic              rst_n_i,
  input  logic              t1_en_i,
  input  logic              t2_en_i,
  input  logic              t1_restart_i,
  input  logic              t2_restart_i,
  input  logic              t1_service_i,
  input  logic              t2_service_i,
  input  mci_pkg::wdt_cnt_t t1_period_i,
  input  mci_pkg::wdt_cnt_t t2_period_i,
  output logic              t1_timeout_o,
  output logic              t2_timeout_o
);

  import mci_pkg::*;

  localparam int NUM_TIMERS = 2;

  // Index 0 is timer1 and index 1 is timer2
  logic [NUM_TIMERS-1:0] run;
  logic [NUM_TIMERS-1:0] restart;
  logic [NUM_TIMERS-1:0] service;
  logic [NUM_TIMERS-1:0] expire;
  logic [NUM_TIMERS-1:0] timeout_q;
  wdt_cnt_t              period [NUM_TIMERS];
  wdt_cnt_t              cnt_q  [NUM_TIMERS];
  logic                  cascade;
  logic                  t2_start;

  //////////////////////////////////////////////////////////////////////
  // Mode and per-timer controls
  //////////////////////////////////////////////////////////////////////

  assign cascade = ~t2_en_i;

  // In cascade mode timer2 only counts while timer1 sits in timeout
  assign run[0] = t1_en_i;
  assign run[1] = cascade ? timeout_q[0] : 1'b1;

  assign restart   = {t2_restart_i, t1_restart_i};
  assign service   = {t2_service_i, t1_service_i};
  assign period[0] = t1_period_i;
  assign period[1] = t2_period_i;

  // A timer expires when it has counted up to its period and nothing restarts it
  always_comb begin
    for (int i = 0; i < NUM_TIMERS; i++) begin
      expire[i] = run[i] & ~timeout_q[i] & ~service[i] & ~restart[i] &
                  (cnt_q[i] >= period[i]);
    end
  end

  // Timer2 starts from zero on the edge that sets timer1's timeout
  assign t2_start = cascade & expire[0];

  //////////////////////////////////////////////////////////////////////
  // Counters and timeout flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      timeout_q <= '0;
      for (int i = 0; i < NUM_TIMERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_TIMERS; i++) begin
        if (service[i]) begin
          timeout_q[i] <= 1'b0;
          cnt_q[i]     <= '0;
        end else if (restart[i] && !timeout_q[i]) begin
          // A pet is ignored once the timer has expired
          cnt_q[i] <= '0;
        end else if (i == 1 && t2_start) begin
          cnt_q[i] <= '0;
        end else if (expire[i]) begin
          // The count holds at the period while the timeout is set
          timeout_q[i] <= 1'b1;
        end else if (run[i] && !timeout_q[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign t1_timeout_o = timeout_q[0];
  assign t2_timeout_o = timeout_q[1];

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_restart_chk
    // An accepted pet or a service leaves the count at zero one cycle later
    restart_zero_a: assert property (
      @(posedge core_clk_i) disable iff (!rst_n_i)
      (service[g] || (restart[g] && !timeout_q[g])) |=> (cnt_q[g] == '0)
    ) else $error("WDT timer%0d count not zero after pet or service", g + 1);
  end

endmodule

// ==== test/mci_tests.txt ====
# Columns: name op a b c d e f, all operands in hex
# PET: a = t1 period, b = number of pets.  IND and CAS: a = t1 period, b = t2 period
# STK: a = fatal events, b = non-fatal events, c = fatal mask, d = non-fatal mask
# STK and AGG: e = expected fatal summary, f = expected non-fatal summary
# AGG: a = fatal sources, b = non-fatal sources, c = fatal mask, d = non-fatal mask
pet_short        PET 8  a  0  0  0 0
pet_long         PET 14 8  0  0  0 0
pet_min          PET 2  c  0  0  0 0
ind_equal        IND 5  5  0  0  0 0
ind_t1_short     IND 4  9  0  0  0 0
ind_t2_short     IND c  3  0  0  0 0
ind_min          IND 1  2  0  0  0 0
cas_basic        CAS 4  6  0  0  0 0
cas_long_t1      CAS 10 3  0  0  0 0
cas_min          CAS 1  1  0  0  0 0
stk_sram         STK 2  0  0  0  1 0
stk_dmi          STK 1  0  0  0  1 0
stk_both_fatal   STK 3  0  0  0  1 0
stk_sram_masked  STK 2  0  2  0  0 0
stk_partial_mask STK 3  0  2  0  1 0
stk_mbox0        STK 0  2  0  0  0 1
stk_mbox1_masked STK 0  1  0  1  0 0
stk_mixed        STK 1  3  1  2  0 1
stk_all_masked   STK 3  3  7  3  0 0
agg_f_bit0       AGG 1  0  0  0  1 0
agg_nf_bit7      AGG 0  80 0  0  0 1
agg_f_masked     AGG 10 0  10 0  0 0
agg_partial      AGG 3  c  1  4  1 1
agg_all_masked   AGG ff ff ff ff 0 0
agg_none         AGG 0  0  0  0  0 0
agg_nf_masked    AGG 40 20 0  20 1 0

// ==== test/mci_top_tb.sv ====
// Testbench for the management block, runs each line of test/mci_tests.txt against the DUT
`timescale 1ns/1ns
`include "mci_config.svh"

module mci_top_tb;

  import mci_pkg::*;

  localparam int SIG_T1    = 0;
  localparam int SIG_T2    = 1;
  localparam int SIG_NMI   = 2;
  localparam int SIG_FATAL = 3;

  localparam int T1_RESTART = 0;
  localparam int T1_SERVICE = 1;
  localparam int T2_SERVICE = 2;

  logic                     core_clk = 1'b0;
  logic                     rst_n;
  logic                     t1_en, t2_en;
  logic                     t1_restart, t2_restart;
  logic                     t1_service, t2_service;
  wdt_cnt_t                 t1_period, t2_period;
  logic                     t1_timeout, t2_timeout;
  logic                     sram_ecc_unc, dmi_axi_collision;
  logic                     mbox0_ecc_unc, mbox1_ecc_unc;
  hw_fatal_t                hw_fatal_clear, hw_fatal_mask, hw_fatal_status;
  hw_non_fatal_t            hw_non_fatal_clear, hw_non_fatal_mask, hw_non_fatal_status;
  logic [`MCI_AGG_ERR_W-1:0] agg_fatal, agg_fatal_mask;
  agg_err_t                 agg_non_fatal, agg_non_fatal_mask;
  logic                     all_error_fatal, all_error_non_fatal;

  string cur_name;
  int    test_errs;
  int    run_cnt  = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;

  mci_top mci_top_i (
    .core_clk_i            (core_clk),
    .rst_n_i               (rst_n),
    .wdt_t1_en_i           (t1_en),
    .wdt_t2_en_i           (t2_en),
    .wdt_t1_restart_i      (t1_restart),
    .wdt_t2_restart_i      (t2_restart),
    .wdt_t1_service_i      (t1_service),
    .wdt_t2_service_i      (t2_service),
    .wdt_t1_period_i       (t1_period),
    .wdt_t2_period_i       (t2_period),
    .wdt_t1_timeout_o      (t1_timeout),
    .wdt_t2_timeout_o      (t2_timeout),
    .sram_ecc_unc_i        (sram_ecc_unc),
    .dmi_axi_collision_i   (dmi_axi_collision),
    .mbox0_ecc_unc_i       (mbox0_ecc_unc),
    .mbox1_ecc_unc_i       (mbox1_ecc_unc),
    .hw_fatal_clear_i      (hw_fatal_clear),
    .hw_fatal_mask_i       (hw_fatal_mask),
    .hw_non_fatal_clear_i  (hw_non_fatal_clear),
    .hw_non_fatal_mask_i   (hw_non_fatal_mask),
    .hw_fatal_status_o     (hw_fatal_status),
    .hw_non_fatal_status_o (hw_non_fatal_status),
    .agg_fatal_i           (agg_fatal),
    .agg_fatal_mask_i      (agg_fatal_mask),
    .agg_non_fatal_i       (agg_non_fatal),
    .agg_non_fatal_mask_i  (agg_non_fatal_mask),
    .all_error_fatal_o     (all_error_fatal),
    .all_error_non_fatal_o (all_error_non_fatal)
  );

  always #4 core_clk = ~core_clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("ERROR %s: %s expected %0d, actual %0d", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  // Counts edges until the selected output is high, -1 when it never rises
  task automatic wait_for(input int sel, input string what, input int limit, output int cycles);
    int  n = 0;
    logic found = 1'b0;
    while (!found && n < limit) begin
      @(posedge core_clk);
      n++;
      @(negedge core_clk);
      case (sel)
        SIG_T1:  found = t1_timeout;
        SIG_T2:  found = t2_timeout;
        SIG_NMI: found = hw_fatal_status.nmi_pin;
        default: found = all_error_fatal;
      endcase
    end
    assert (found) else begin
      $display("Test %s: %s did not rise within %0d cycles", cur_name, what, limit);
      test_errs++;
    end
    cycles = found ? n : -1;
  endtask

  task automatic pulse_wdt(input int which);
    @(posedge core_clk);
    case (which)
      T1_RESTART: t1_restart <= 1'b1;
      T1_SERVICE: t1_service <= 1'b1;
      default:    t2_service <= 1'b1;
    endcase
    @(posedge core_clk);
    t1_restart <= 1'b0;
    t1_service <= 1'b0;
    t2_service <= 1'b0;
  endtask

  // Timers stopped in cascade mode, no events, no masks, optional clear of everything
  task automatic drive_idle(input logic clr);
    t1_en              <= 1'b0;
    t2_en              <= 1'b0;
    t1_restart         <= 1'b0;
    t2_restart         <= 1'b0;
    t1_service         <= clr;
    t2_service         <= clr;
    sram_ecc_unc       <= 1'b0;
    dmi_axi_collision  <= 1'b0;
    mbox0_ecc_unc      <= 1'b0;
    mbox1_ecc_unc      <= 1'b0;
    hw_fatal_clear     <= {3{clr}};
    hw_non_fatal_clear <= {2{clr}};
    hw_fatal_mask      <= '0;
    hw_non_fatal_mask  <= '0;
    agg_fatal          <= '0;
    agg_fatal_mask     <= '0;
    agg_non_fatal      <= '0;
    agg_non_fatal_mask <= '0;
  endtask

  // Three edges after the clear the whole error pipeline is empty again
  task automatic return_to_idle();
    @(posedge core_clk);
    drive_idle(1'b1);
    @(posedge core_clk);
    drive_idle(1'b0);
    repeat (3) @(posedge core_clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test operations
  //////////////////////////////////////////////////////////////////////

  // Pet gaps never exceed the period, so the count stays below it
  task automatic run_pet(input int period, input int pets);
    int   gap;
    logic seen = 1'b0;
    @(posedge core_clk);
    t1_period  <= wdt_cnt_t'(period);
    t1_en      <= 1'b1;
    t1_restart <= 1'b1;
    for (int n = 0; n < pets; n++) begin
      gap = 1 + int'($urandom % period);
      for (int c = 0; c < gap; c++) begin
        @(posedge core_clk);
        t1_restart <= (c == gap - 1);
        @(negedge core_clk);
        seen |= t1_timeout;
      end
    end
    @(posedge core_clk);
    t1_restart <= 1'b0;
    check_value("t1 timeout seen during pets", 0, int'(seen));
  endtask

  task automatic run_ind(input int p1, input int p2);
    int n = 0;
    int c1 = -1;
    int c2 = -1;
    int limit;
    limit = ((p1 > p2) ? p1 : p2) + 16;
    @(posedge core_clk);
    t1_period  <= wdt_cnt_t'(p1);
    t2_period  <= wdt_cnt_t'(p2);
    t1_en      <= 1'b1;
    t2_en      <= 1'b1;
    t1_restart <= 1'b1;
    t2_restart <= 1'b1;
    @(posedge core_clk);
    t1_restart <= 1'b0;
    t2_restart <= 1'b0;
    while ((c1 < 0 || c2 < 0) && n < limit) begin
      @(posedge core_clk);
      n++;
      @(negedge core_clk);
      if (c1 < 0 && t1_timeout) c1 = n;
      if (c2 < 0 && t2_timeout) c2 = n;
    end
    assert (c1 >= 0 && c2 >= 0) else begin
      $display("Test %s: a timer did not expire within %0d cycles", cur_name, limit);
      test_errs++;
    end
    check_value("t1 expiry cycles", p1 + 1, c1);
    check_value("t2 expiry cycles", p2 + 1, c2);
    pulse_wdt(T1_SERVICE);
    wait_for(SIG_T1, "t1 timeout after service", p1 + 16, n);
    check_value("t1 cycles after service", p1 + 1, n);
    pulse_wdt(T2_SERVICE);
    wait_for(SIG_T2, "t2 timeout after service", p2 + 16, n);
    check_value("t2 cycles after service", p2 + 1, n);
  endtask

  task automatic run_cas(input int p1, input int p2);
    int n;
    @(posedge core_clk);
    t1_period <= wdt_cnt_t'(p1);
    t2_period <= wdt_cnt_t'(p2);
    t1_en     <= 1'b1;
    t2_en     <= 1'b0;
    pulse_wdt(T1_RESTART);
    wait_for(SIG_T1, "t1 timeout", p1 + 16, n);
    check_value("t1 expiry cycles", p1 + 1, n);
    wait_for(SIG_T2, "t2 timeout", p2 + 16, n);
    check_value("t2 expiry cycles after t1", p2 + 1, n);
    wait_for(SIG_NMI, "nmi_pin status", 8, n);
    check_value("nmi_pin status delay", 1, n);
    wait_for(SIG_FATAL, "all_error_fatal_o", 8, n);
    check_value("fatal summary delay", 1, n);
  endtask

  task automatic run_sticky(input logic [31:0] fev, nfev, fmask, nfmask, exp_f, exp_nf);
    @(posedge core_clk);
    hw_fatal_mask     <= fmask[2:0];
    hw_non_fatal_mask <= nfmask[1:0];
    @(posedge core_clk);
    sram_ecc_unc      <= fev[1];
    dmi_axi_collision <= fev[0];
    mbox0_ecc_unc     <= nfev[1];
    mbox1_ecc_unc     <= nfev[0];
    @(posedge core_clk);
    sram_ecc_unc      <= 1'b0;
    dmi_axi_collision <= 1'b0;
    mbox0_ecc_unc     <= 1'b0;
    mbox1_ecc_unc     <= 1'b0;
    @(negedge core_clk);
    check_value("fatal status after event", int'(fev[1:0]), int'(hw_fatal_status));
    check_value("non-fatal status after event", int'(nfev[1:0]), int'(hw_non_fatal_status));
    @(negedge core_clk);
    check_value("fatal summary", int'(exp_f[0]), int'(all_error_fatal));
    check_value("non-fatal summary", int'(exp_nf[0]), int'(all_error_non_fatal));
    repeat (3) @(negedge core_clk);
    check_value("fatal status held", int'(fev[1:0]), int'(hw_fatal_status));
    check_value("non-fatal status held", int'(nfev[1:0]), int'(hw_non_fatal_status));
    @(posedge core_clk);
    hw_fatal_clear     <= {1'b0, fev[1:0]};
    hw_non_fatal_clear <= nfev[1:0];
    @(posedge core_clk);
    hw_fatal_clear     <= '0;
    hw_non_fatal_clear <= '0;
    @(negedge core_clk);
    check_value("fatal status after clear", 0, int'(hw_fatal_status));
    check_value("non-fatal status after clear", 0, int'(hw_non_fatal_status));
    check_value("fatal summary one cycle after clear", int'(exp_f[0]), int'(all_error_fatal));
    check_value("non-fatal summary one cycle after clear", int'(exp_nf[0]),
                int'(all_error_non_fatal));
    @(negedge core_clk);
    check_value("fatal summary after clear", 0, int'(all_error_fatal));
    check_value("non-fatal summary after clear", 0, int'(all_error_non_fatal));
  endtask

  // Summaries follow the sources three edges after they are driven
  task automatic run_agg(input logic [31:0] fsrc, nfsrc, fmask, nfmask, exp_f, exp_nf);
    @(posedge core_clk);
    agg_fatal          <= fsrc[`MCI_AGG_ERR_W-1:0];
    agg_non_fatal      <= nfsrc[`MCI_AGG_ERR_W-1:0];
    agg_fatal_mask     <= fmask[`MCI_AGG_ERR_W-1:0];
    agg_non_fatal_mask <= nfmask[`MCI_AGG_ERR_W-1:0];
    repeat (2) @(posedge core_clk);
    @(negedge core_clk);
    check_value("fatal summary before sync", 0, int'(all_error_fatal));
    check_value("non-fatal summary before sync", 0, int'(all_error_non_fatal));
    @(negedge core_clk);
    check_value("fatal summary", int'(exp_f[0]), int'(all_error_fatal));
    check_value("non-fatal summary", int'(exp_nf[0]), int'(all_error_non_fatal));
  endtask

  task automatic run_test(input string name, input string op,
                          input logic [31:0] a, b, c, d, e, f);
    cur_name  = name;
    test_errs = 0;
    case (op)
      "PET": run_pet(int'(a), int'(b));
      "IND": run_ind(int'(a), int'(b));
      "CAS": run_cas(int'(a), int'(b));
      "STK": run_sticky(a, b, c, d, e, f);
      "AGG": run_agg(a, b, c, d, e, f);
      default: begin
        $display("Test %s: unknown operation %s in the test file", name, op);
        test_errs++;
      end
    endcase
    return_to_idle();
    run_cnt++;
    if (test_errs == 0) begin
      pass_cnt++;
      $display("Test %-18s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %-18s failed with %0d errors", name, test_errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a, b, c, d, e, f;
    void'($urandom(32'he9c9_751c));
    drive_idle(1'b0);
    t1_period <= '0;
    t2_period <= '0;
    rst_n     <= 1'b0;
    repeat (2) @(posedge core_clk);
    rst_n <= 1'b1;
    @(posedge core_clk);
    fd = $fopen("test/mci_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file test/mci_tests.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, a, b, c, d, e, f);
          if (n == 8) run_test(name, op, a, b, c, d, e, f);
        end
      end
      $fclose(fd);
    end
    $display("Tests run %0d, passed %0d, failed %0d", run_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && run_cnt > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
